// ==== tb_quad_bram_input.txt ====
// Columns: num_input_cols num_input_rows num_output_cols num_output_rows
//          expected fetches, expected passes, expected pfb reads (decimal)
3 3 1 1 4 2 16
5 5 3 3 6 4 36
7 4 5 2 5 3 40
9 6 7 4 7 5 70
4 8 2 6 9 7 45
12 5 10 3 6 4 78

// ==== src.f ====
accel_geom_pkg.sv
quad_ctrl_pkg.sv
job_ctrl_fsm.sv
pfb_reader.sv
pix_seq_reader.sv
ce_strobe_chain.sv
quad_bram_ctrl.sv
tb_quad_bram_ctrl.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_quad_bram_ctrl
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_quad_bram_ctrl.sv ====
`timescale 1ns/10ps

module tb_quad_bram_ctrl;

    import accel_geom_pkg::*;
    import quad_ctrl_pkg::*;

    // Read strobe history deep enough for the last CE
    localparam int HIST_LEN = PIX_SEQ_RD_LATENCY + NUM_CE;
    localparam int MAX_JOBS = 16;

    logic                   clk = 1'b0;
    logic                   rst = 1'b1;
    logic [DIM_W-1:0]       num_input_cols;
    logic [DIM_W-1:0]       num_input_rows;
    logic [DIM_W-1:0]       num_output_cols;
    logic [DIM_W-1:0]       num_output_rows;
    logic                   job_start;
    logic                   job_fetch_ack;
    logic                   job_fetch_complete;
    logic                   job_complete_ack;
    logic                   last_kernel;
    logic                   pipeline_flushed;
    logic [PFB_COUNT_W-1:0] pfb_full_count;
    logic [PIX_SEQ_W-1:0]   pix_seq_data_full_count;
    logic                   job_accept;
    logic                   job_fetch_request;
    logic                   job_fetch_in_progress;
    logic                   job_complete;
    ctrl_state_t            state;
    logic                   pfb_rden;
    logic [DIM_W-1:0]       input_row;
    logic [DIM_W-1:0]       input_col;
    logic                   pix_seq_bram_rden;
    logic [PIX_SEQ_W-1:0]   pix_seq_bram_rd_addr;
    logic [CYC_W-1:0]       cycle_counter;
    logic [NUM_CE-1:0]      ce_execute;
    logic [NUM_CE-1:0]      next_kernel;

    // Job table with one row per line of the input file
    int job_tab [0:MAX_JOBS-1][0:6];
    int num_jobs = 0;

    int checks       = 0;
    int mismatches   = 0;
    int other_errors = 0;
    int cycle_count  = 0;
    int cycle_limit  = 1000000;

    // Monitor state and running totals
    logic [HIST_LEN-1:0] rden_hist = '0;
    logic [DIM_W-1:0]    exp_row = '0;
    logic [DIM_W-1:0]    exp_col = '0;
    logic                complete_seen = 1'b0;
    logic                inprog_seen = 1'b0;
    logic                prev_rden = 1'b0;
    int                  read_idx = 0;
    int                  accept_total = 0;
    int                  fetch_total = 0;
    int                  rden_total = 0;
    int                  pass_total = 0;
    int                  kern_total = 0;

    quad_bram_ctrl UUT (.*);

    always #50 clk = ~clk;

    // Cycle budget for the whole run
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("error: timeout after %0d cycles, a job never completed", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_bit(input logic act, input logic exp, input string what);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    task automatic check_dim(input logic [DIM_W-1:0] act, input logic [DIM_W-1:0] exp,
                             input string what);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, act, exp);
        end
    endtask

    task automatic check_addr(input logic [PIX_SEQ_W-1:0] act,
                              input logic [PIX_SEQ_W-1:0] exp, input string what);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, act, exp);
        end
    endtask

    task automatic check_cyc(input logic [CYC_W-1:0] act, input logic [CYC_W-1:0] exp,
                             input string what);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, act, exp);
        end
    endtask

    task automatic check_ce(input logic [NUM_CE-1:0] act, input logic [NUM_CE-1:0] exp,
                            input string what);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    task automatic check_state(input ctrl_state_t act, input ctrl_state_t exp,
                               input string what);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s is %s, expected %s", $time, what,
                     act.name(), exp.name());
        end
    endtask

    ////////////////////
    // Output monitor
    ////////////////////

    // Outputs settle after the rising edge and are sampled on the falling one
    always @(negedge clk) begin
        logic [NUM_CE-1:0] exp_exec;
        logic [NUM_CE-1:0] exp_kern;
        int                k;
        // Execute follows the read strobe LAT+k cycles back
        // Next-kernel marks the last read of a pass
        for (k = 0; k < NUM_CE; k++) begin
            exp_exec[k] = rden_hist[PIX_SEQ_RD_LATENCY + k - 1];
            exp_kern[k] = rden_hist[PIX_SEQ_RD_LATENCY + k - 1]
                          & ~rden_hist[PIX_SEQ_RD_LATENCY + k - 2];
        end
        check_ce(ce_execute, exp_exec, "ce_execute vs read strobe history");
        check_ce(next_kernel, exp_kern, "next_kernel at end of pass");
        rden_hist = {rden_hist[HIST_LEN-2:0], pix_seq_bram_rden};

        // Completion ack clears the input position
        if (complete_seen && !job_complete) begin
            exp_row = '0;
            exp_col = '0;
        end
        check_dim(input_row, exp_row, "input_row");
        check_dim(input_col, exp_col, "input_col");
        if (pfb_rden) begin
            rden_total++;
            if (exp_col == num_input_cols) begin
                exp_col = '0;
                exp_row = exp_row + DIM_W'(1);
            end else begin
                exp_col = exp_col + DIM_W'(1);
            end
        end

        // Sequence reads of one pass
        if (pix_seq_bram_rden) begin
            check_addr(pix_seq_bram_rd_addr, PIX_SEQ_W'(read_idx), "sequence read address");
            check_cyc(cycle_counter, CYC_W'(read_idx % WINDOW_NUM_CYCLES), "cycle_counter");
            read_idx++;
        end else if (prev_rden) begin
            check_addr(PIX_SEQ_W'(read_idx), pix_seq_data_full_count, "reads in one pass");
            pass_total++;
            read_idx = 0;
        end

        if (inprog_seen && !job_fetch_in_progress) begin
            fetch_total++;
        end
        if (job_accept) begin
            accept_total++;
        end
        if (next_kernel[0]) begin
            kern_total++;
        end
        prev_rden     = pix_seq_bram_rden;
        complete_seen = job_complete;
        inprog_seen   = job_fetch_in_progress;
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic load_jobs();
        int    fd;
        int    got;
        int    n;
        int    i;
        int    f [0:6];
        string line;
        fd = $fopen("tb_quad_bram_input.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("error: cannot open tb_quad_bram_input.txt");
        end else begin
            while (!$feof(fd) && num_jobs < MAX_JOBS) begin
                got = $fgets(line, fd);
                n = 0;
                if (got != 0) begin
                    n = $sscanf(line, "%d %d %d %d %d %d %d",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                end
                // Comment and blank lines give fewer fields
                if (n == 7) begin
                    for (i = 0; i < 7; i++) begin
                        job_tab[num_jobs][i] = f[i];
                    end
                    num_jobs++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Request level must hold through a random ack delay
    task automatic serve_fetch();
        int d;
        d = $urandom_range(5);
        repeat (d) begin
            check_bit(job_fetch_request, 1'b1, "fetch request held before ack");
            @(negedge clk);
        end
        check_state(state, WAIT_PFB_LOAD, "state while fetching");
        job_fetch_ack = 1'b1;
        @(negedge clk);
        job_fetch_ack = 1'b0;
        check_bit(job_fetch_request, 1'b0, "fetch request dropped after ack");
        check_bit(job_fetch_in_progress, 1'b1, "fetch in progress after ack");
        d = $urandom_range(5);
        repeat (d) begin
            @(negedge clk);
            check_bit(job_fetch_in_progress, 1'b1, "fetch in progress until complete");
            check_bit(job_fetch_request, 1'b0, "fetch request stays low after ack");
        end
        job_fetch_complete = 1'b1;
        @(negedge clk);
        job_fetch_complete = 1'b0;
        check_bit(job_fetch_in_progress, 1'b0, "fetch in progress after complete");
    endtask

    // Completion after flush is held across a delayed ack
    task automatic finish_job();
        int d;
        d = $urandom_range(5);
        repeat (d) begin
            check_bit(job_complete, 1'b0, "job_complete before flush");
            @(negedge clk);
        end
        check_bit(job_complete, 1'b0, "job_complete before flush");
        pipeline_flushed = 1'b1;
        @(negedge clk);
        pipeline_flushed = 1'b0;
        check_bit(job_complete, 1'b1, "job_complete after flush");
        check_state(state, SEND_COMPLETE, "state after flush");
        d = $urandom_range(5);
        repeat (d) begin
            @(negedge clk);
            check_bit(job_complete, 1'b1, "job_complete held until ack");
        end
        job_complete_ack = 1'b1;
        @(negedge clk);
        job_complete_ack = 1'b0;
        check_bit(job_complete, 1'b0, "job_complete after ack");
        check_dim(input_row, '0, "input_row after completion");
        check_dim(input_col, '0, "input_col after completion");
        @(negedge clk);
        check_state(state, IDLE, "state one cycle after ack");
    endtask

    task automatic run_job(input int j);
        int acc0;
        int fet0;
        int rd0;
        int pas0;
        int ker0;
        bit done;
        num_input_cols          = DIM_W'(job_tab[j][0]);
        num_input_rows          = DIM_W'(job_tab[j][1]);
        num_output_cols         = DIM_W'(job_tab[j][2]);
        num_output_rows         = DIM_W'(job_tab[j][3]);
        // One fetch fills one row
        // Six reads per window
        pfb_full_count          = PFB_COUNT_W'(job_tab[j][0] + 1);
        pix_seq_data_full_count = PIX_SEQ_W'(WINDOW_NUM_CYCLES * (job_tab[j][2] + 1));
        if (job_tab[j][4] != job_tab[j][1] + 1 || job_tab[j][5] != job_tab[j][3] + 1
            || job_tab[j][6] != (job_tab[j][1] + 1) * (job_tab[j][0] + 1)) begin
            other_errors++;
            $display("error: job %0d expected counts in the file break the count rules", j);
        end
        acc0 = accept_total;
        fet0 = fetch_total;
        rd0  = rden_total;
        pas0 = pass_total;
        ker0 = kern_total;
        job_start = 1'b1;
        @(negedge clk);
        job_start = 1'b0;
        check_bit(job_accept, 1'b1, "job_accept one cycle after job_start");
        check_state(state, PRIME_BUFFER, "state after accept");
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (job_fetch_request) begin
                serve_fetch();
            end else if (state == WAIT_JOB_DONE) begin
                finish_job();
                done = 1'b1;
            end
        end
        check_dim(DIM_W'(accept_total - acc0), DIM_W'(1), "job_accept pulses");
        check_dim(DIM_W'(fetch_total - fet0), DIM_W'(job_tab[j][4]), "fetches");
        check_dim(DIM_W'(pass_total - pas0), DIM_W'(job_tab[j][5]), "passes");
        check_dim(DIM_W'(rden_total - rd0), DIM_W'(job_tab[j][6]), "pfb_rden pulses");
        check_dim(DIM_W'(kern_total - ker0), DIM_W'(job_tab[j][5]), "next_kernel[0] pulses");
    endtask

    initial begin
        int j;
        int est;
        void'($urandom(32'h8a3968ab));
        num_input_cols          = '0;
        num_input_rows          = '0;
        num_output_cols         = '0;
        num_output_rows         = '0;
        job_start               = 1'b0;
        job_fetch_ack           = 1'b0;
        job_fetch_complete      = 1'b0;
        job_complete_ack        = 1'b0;
        last_kernel             = 1'b1;
        pipeline_flushed        = 1'b0;
        pfb_full_count          = '0;
        pix_seq_data_full_count = '0;
        load_jobs();
        // Budget per job from passes and fetches
        est = 20;
        for (j = 0; j < num_jobs; j++) begin
            est += job_tab[j][5] * (WINDOW_NUM_CYCLES * (job_tab[j][2] + 1) + NUM_CE + 20)
                   + job_tab[j][4] * (job_tab[j][0] + 1 + 20) + 200;
        end
        cycle_limit = 2 * est;
        if (num_jobs == 0) begin
            other_errors++;
            $display("error: no jobs found in tb_quad_bram_input.txt");
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        // Idle levels after reset
        check_bit(job_accept, 1'b0, "job_accept after reset");
        check_bit(job_fetch_request, 1'b0, "job_fetch_request after reset");
        check_bit(job_fetch_in_progress, 1'b0, "job_fetch_in_progress after reset");
        check_bit(job_complete, 1'b0, "job_complete after reset");
        check_bit(pfb_rden, 1'b0, "pfb_rden after reset");
        check_bit(pix_seq_bram_rden, 1'b0, "pix_seq_bram_rden after reset");
        check_ce(ce_execute, '0, "ce_execute after reset");
        check_ce(next_kernel, '0, "next_kernel after reset");
        check_state(state, IDLE, "state after reset");

        // Jobs run back to back
        for (j = 0; j < num_jobs; j++) begin
            run_job(j);
        end

        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== quad_bram_ctrl.sv ====
`timescale 1ns/10ps

module quad_bram_ctrl (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [accel_geom_pkg::DIM_W-1:0]       num_input_cols,
    input  logic [accel_geom_pkg::DIM_W-1:0]       num_input_rows,
    input  logic [accel_geom_pkg::DIM_W-1:0]       num_output_cols,
    input  logic [accel_geom_pkg::DIM_W-1:0]       num_output_rows,
    input  logic                                   job_start,
    input  logic                                   job_fetch_ack,
    input  logic                                   job_fetch_complete,
    input  logic                                   job_complete_ack,
    input  logic                                   last_kernel,
    input  logic                                   pipeline_flushed,
    input  logic [accel_geom_pkg::PFB_COUNT_W-1:0] pfb_full_count,
    input  logic [accel_geom_pkg::PIX_SEQ_W-1:0]   pix_seq_data_full_count,
    output logic                                   job_accept,
    output logic                                   job_fetch_request,
    output logic                                   job_fetch_in_progress,
    output logic                                   job_complete,
    output quad_ctrl_pkg::ctrl_state_t             state,
    output logic                                   pfb_rden,
    output logic [accel_geom_pkg::DIM_W-1:0]       input_row,
    output logic [accel_geom_pkg::DIM_W-1:0]       input_col,
    output logic                                   pix_seq_bram_rden,
    output logic [accel_geom_pkg::PIX_SEQ_W-1:0]   pix_seq_bram_rd_addr,
    output logic [accel_geom_pkg::CYC_W-1:0]       cycle_counter,
    output logic [accel_geom_pkg::NUM_CE-1:0]      ce_execute,
    output logic [accel_geom_pkg::NUM_CE-1:0]      next_kernel
);

    import accel_geom_pkg::*;
    import quad_ctrl_pkg::*;

    // FSM to readers
    logic pfb_drain;
    logic pass_start;
    // Readers and chain back to FSM
    logic pfb_empty;
    logic last_col_window;
    logic pass_done;

    job_ctrl_fsm u_fsm (
        .clk                   (clk),
        .rst                   (rst),
        .job_start             (job_start),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .job_complete_ack      (job_complete_ack),
        .pipeline_flushed      (pipeline_flushed),
        .last_kernel           (last_kernel),
        .pfb_empty             (pfb_empty),
        .input_row             (input_row),
        .num_input_rows        (num_input_rows),
        .num_output_rows       (num_output_rows),
        .pass_done             (pass_done),
        .job_accept            (job_accept),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .job_complete          (job_complete),
        .state                 (state),
        .pfb_drain             (pfb_drain),
        .pass_start            (pass_start)
    );

    pfb_reader u_pfb (
        .clk                   (clk),
        .rst                   (rst),
        .job_fetch_complete    (job_fetch_complete),
        .job_fetch_in_progress (job_fetch_in_progress),
        .pfb_full_count        (pfb_full_count),
        .pfb_drain             (pfb_drain),
        .job_complete_ack      (job_complete_ack),
        .num_input_cols        (num_input_cols),
        .pfb_rden              (pfb_rden),
        .pfb_empty             (pfb_empty),
        .input_row             (input_row),
        .input_col             (input_col)
    );

    pix_seq_reader u_seq (
        .clk                     (clk),
        .rst                     (rst),
        .pass_start              (pass_start),
        .pix_seq_data_full_count (pix_seq_data_full_count),
        .num_output_cols         (num_output_cols),
        .pix_seq_bram_rden       (pix_seq_bram_rden),
        .pix_seq_bram_rd_addr    (pix_seq_bram_rd_addr),
        .cycle_counter           (cycle_counter),
        .last_col_window         (last_col_window)
    );

    ce_strobe_chain u_chain (
        .clk               (clk),
        .rst               (rst),
        .pix_seq_bram_rden (pix_seq_bram_rden),
        .last_col_window   (last_col_window),
        .ce_execute        (ce_execute),
        .next_kernel       (next_kernel),
        .pass_done         (pass_done)
    );

endmodule

// ==== ce_strobe_chain.sv ====
`timescale 1ns/10ps

module ce_strobe_chain (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              pix_seq_bram_rden,
    input  logic                              last_col_window,
    output logic [accel_geom_pkg::NUM_CE-1:0] ce_execute,
    output logic [accel_geom_pkg::NUM_CE-1:0] next_kernel,
    output logic                              pass_done
);

    import accel_geom_pkg::*;

    // BRAM latency stages followed by one stage per CE
    // bit j holds the input from j+1 cycles back
    logic [PIX_SEQ_RD_LATENCY+NUM_CE-2:0] exec_sr;
    logic [PIX_SEQ_RD_LATENCY+NUM_CE-2:0] kern_sr;
    // Execute chain was busy last cycle
    logic                                 exec_busy;

    assign ce_execute  = exec_sr[PIX_SEQ_RD_LATENCY+NUM_CE-2:PIX_SEQ_RD_LATENCY-1];
    assign next_kernel = kern_sr[PIX_SEQ_RD_LATENCY+NUM_CE-2:PIX_SEQ_RD_LATENCY-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_sr <= '0;
            kern_sr <= '0;
        end else begin
            exec_sr <= {exec_sr[PIX_SEQ_RD_LATENCY+NUM_CE-3:0], pix_seq_bram_rden};
            kern_sr <= {kern_sr[PIX_SEQ_RD_LATENCY+NUM_CE-3:0], last_col_window};
        end
    end

    ////////////////////
    // Pass drain detect
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_busy <= 1'b0;
            pass_done <= 1'b0;
        end else begin
            exec_busy <= |ce_execute;
            // Falling edge of the chain activity
            pass_done <= exec_busy && !(|ce_execute);
        end
    end

endmodule

// ==== pix_seq_reader.sv ====
`timescale 1ns/10ps

module pix_seq_reader (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 pass_start,
    input  logic [accel_geom_pkg::PIX_SEQ_W-1:0] pix_seq_data_full_count,
    input  logic [accel_geom_pkg::DIM_W-1:0]     num_output_cols,
    output logic                                 pix_seq_bram_rden,
    output logic [accel_geom_pkg::PIX_SEQ_W-1:0] pix_seq_bram_rd_addr,
    output logic [accel_geom_pkg::CYC_W-1:0]     cycle_counter,
    output logic                                 last_col_window
);

    import accel_geom_pkg::*;

    // Reads left in the current pass
    logic [PIX_SEQ_W-1:0] seq_remaining;
    logic [DIM_W-1:0]     output_col;
    logic                 window_end;

    assign pix_seq_bram_rden = (seq_remaining != '0);
    // Final read of a 3x3 window
    assign window_end        = pix_seq_bram_rden
                               && (cycle_counter == CYC_W'(WINDOW_NUM_CYCLES - 1));
    assign last_col_window   = window_end && (output_col == num_output_cols);

    ////////////////////
    // Sequence reads
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            seq_remaining        <= '0;
            pix_seq_bram_rd_addr <= '0;
        end else if (pass_start) begin
            seq_remaining        <= pix_seq_data_full_count;
            pix_seq_bram_rd_addr <= '0;
        end else if (pix_seq_bram_rden) begin
            seq_remaining        <= seq_remaining - 1'b1;
            pix_seq_bram_rd_addr <= pix_seq_bram_rd_addr + 1'b1;
        end
    end

    // Window cycle and output column tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_counter <= '0;
            output_col    <= '0;
        end else if (pass_start) begin
            cycle_counter <= '0;
            output_col    <= '0;
        end else if (window_end) begin
            cycle_counter <= '0;
            if (output_col == num_output_cols) begin
                output_col <= '0;
            end else begin
                output_col <= output_col + 1'b1;
            end
        end else if (pix_seq_bram_rden) begin
            cycle_counter <= cycle_counter + 1'b1;
        end
    end

endmodule

// ==== pfb_reader.sv ====
`timescale 1ns/10ps

module pfb_reader (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  job_fetch_complete,
    input  logic                                  job_fetch_in_progress,
    input  logic [accel_geom_pkg::PFB_COUNT_W-1:0] pfb_full_count,
    input  logic                                  pfb_drain,
    input  logic                                  job_complete_ack,
    input  logic [accel_geom_pkg::DIM_W-1:0]      num_input_cols,
    output logic                                  pfb_rden,
    output logic                                  pfb_empty,
    output logic [accel_geom_pkg::DIM_W-1:0]      input_row,
    output logic [accel_geom_pkg::DIM_W-1:0]      input_col
);

    import accel_geom_pkg::*;

    // Words still held in the prefetch buffer
    logic [PFB_COUNT_W-1:0] pfb_count;

    assign pfb_empty = (pfb_count == '0);
    // One read per stored word, back to back
    assign pfb_rden  = pfb_drain && !pfb_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            pfb_count <= '0;
        end else if (job_fetch_complete && job_fetch_in_progress) begin
            pfb_count <= pfb_full_count;
        end else if (pfb_rden) begin
            pfb_count <= pfb_count - 1'b1;
        end
    end

    ////////////////////
    // Input position
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            input_row <= '0;
            input_col <= '0;
        end else if (job_complete_ack) begin
            input_row <= '0;
            input_col <= '0;
        end else if (pfb_rden) begin
            // Last column of a row, wrap to the next row
            if (input_col == num_input_cols) begin
                input_col <= '0;
                input_row <= input_row + 1'b1;
            end else begin
                input_col <= input_col + 1'b1;
            end
        end
    end

endmodule

// ==== job_ctrl_fsm.sv ====
`timescale 1ns/10ps

module job_ctrl_fsm (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               job_start,
    input  logic                               job_fetch_ack,
    input  logic                               job_fetch_complete,
    input  logic                               job_complete_ack,
    input  logic                               pipeline_flushed,
    input  logic                               last_kernel,
    input  logic                               pfb_empty,
    input  logic [accel_geom_pkg::DIM_W-1:0]   input_row,
    input  logic [accel_geom_pkg::DIM_W-1:0]   num_input_rows,
    input  logic [accel_geom_pkg::DIM_W-1:0]   num_output_rows,
    input  logic                               pass_done,
    output logic                               job_accept,
    output logic                               job_fetch_request,
    output logic                               job_fetch_in_progress,
    output logic                               job_complete,
    output quad_ctrl_pkg::ctrl_state_t         state,
    output logic                               pfb_drain,
    output logic                               pass_start
);

    import accel_geom_pkg::*;
    import quad_ctrl_pkg::*;

    // Phase to resume once a fetch completes
    ctrl_state_t       return_state;
    logic              fetch_acked;
    logic              complete_acked;
    logic [DIM_W-1:0]  output_row;
    // Output row after the pass that just ended
    logic [DIM_W-1:0]  output_row_nxt;

    assign output_row_nxt = last_kernel ? output_row + 1'b1 : output_row;

    // Fetch in flight from ack until complete
    always_ff @(posedge clk) begin
        if (rst) begin
            job_fetch_in_progress <= 1'b0;
        end else if (job_fetch_complete) begin
            job_fetch_in_progress <= 1'b0;
        end else if (job_fetch_ack) begin
            job_fetch_in_progress <= 1'b1;
        end
    end

    ////////////////////
    // Phase sequencing
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= IDLE;
            return_state      <= IDLE;
            fetch_acked       <= 1'b0;
            complete_acked    <= 1'b0;
            output_row        <= '0;
            job_accept        <= 1'b0;
            job_fetch_request <= 1'b0;
            job_complete      <= 1'b0;
            pfb_drain         <= 1'b0;
            pass_start        <= 1'b0;
        end else begin
            // Single-cycle strobes
            job_accept <= 1'b0;
            pass_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        output_row <= '0;
                        state      <= PRIME_BUFFER;
                    end
                end
                PRIME_BUFFER: begin
                    if (pfb_drain) begin
                        // Row drained, decide on the next cycle
                        if (pfb_empty) begin
                            pfb_drain <= 1'b0;
                        end
                    end else if (input_row == DIM_W'(PRIME_ROWS)) begin
                        pass_start <= 1'b1;
                        state      <= CE_ACTIVE;
                    end else begin
                        job_fetch_request <= 1'b1;
                        return_state      <= PRIME_BUFFER;
                        state             <= WAIT_PFB_LOAD;
                    end
                end
                WAIT_PFB_LOAD: begin
                    // Request level drops on ack and stays down
                    if (job_fetch_ack) begin
                        job_fetch_request <= 1'b0;
                        fetch_acked       <= 1'b1;
                    end else begin
                        job_fetch_request <= !fetch_acked;
                    end
                    if (job_fetch_complete && job_fetch_in_progress) begin
                        fetch_acked <= 1'b0;
                        pfb_drain   <= 1'b1;
                        state       <= return_state;
                    end
                end
                CE_ACTIVE: begin
                    if (pfb_drain) begin
                        // Extra row is in, start the next pass
                        if (pfb_empty) begin
                            pfb_drain  <= 1'b0;
                            pass_start <= 1'b1;
                        end
                    end else if (pass_done) begin
                        output_row <= output_row_nxt;
                        if (output_row_nxt > num_output_rows) begin
                            state <= WAIT_JOB_DONE;
                        end else if (input_row <= num_input_rows) begin
                            job_fetch_request <= 1'b1;
                            return_state      <= CE_ACTIVE;
                            state             <= WAIT_PFB_LOAD;
                        end else begin
                            // All input rows already buffered
                            pass_start <= 1'b1;
                        end
                    end
                end
                WAIT_JOB_DONE: begin
                    if (pipeline_flushed) begin
                        job_complete <= 1'b1;
                        state        <= SEND_COMPLETE;
                    end
                end
                SEND_COMPLETE: begin
                    // Ack drops completion, IDLE one cycle later
                    if (complete_acked) begin
                        complete_acked <= 1'b0;
                        state          <= IDLE;
                    end else if (job_complete_ack) begin
                        job_complete   <= 1'b0;
                        complete_acked <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== quad_ctrl_pkg.sv ====
package quad_ctrl_pkg;

    // Job phases of the row-buffer controller
    typedef enum logic [2:0] {
        // Waiting for job_start
        IDLE,
        // Fetch and drain the first rows
        PRIME_BUFFER,
        // Fetch request out, waiting for ack and complete
        WAIT_PFB_LOAD,
        // Execution passes along the CE chain
        CE_ACTIVE,
        // Waiting for the pipeline to flush
        WAIT_JOB_DONE,
        // Completion held until acked
        SEND_COMPLETE
    } ctrl_state_t;

endpackage

// ==== accel_geom_pkg.sv ====
package accel_geom_pkg;

    ////////////////////
    // Geometry widths
    ////////////////////

    // Row, column and count fields
    localparam int DIM_W = 16;

    // Words left in the prefetch buffer
    localparam int PFB_COUNT_W = 10;

    // Sequence BRAM address and length
    localparam int PIX_SEQ_W = 12;

    ////////////////////
    // Compute engines
    ////////////////////

    localparam int NUM_AWE        = 4;
    localparam int NUM_CE_PER_AWE = 2;
    // Length of the execute and next-kernel chains
    localparam int NUM_CE         = NUM_AWE * NUM_CE_PER_AWE;

    ////////////////////
    // Window and latency
    ////////////////////

    // Reads per 3x3 window
    localparam int WINDOW_NUM_CYCLES  = 6;
    localparam int CYC_W              = 3;
    localparam int PIX_SEQ_RD_LATENCY = 3;
    // Input rows loaded before the first pass
    localparam int PRIME_ROWS         = 4;

endpackage
